//--- files.f
+incdir+tests
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/de_pipe_reg.sv
logic/exec_unit.sv
logic/de_ex_slice.sv
tests/tb_de_ex_slice.sv

//--- logic/de_ex_slice.sv
// decode and execute slice top with decoder, register file, d/e register and execute unit
`timescale 1ns/1ns

module de_ex_slice (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,       // from hazard unit
    input  rv_isa_pkg::instr_u                instr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]       pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0]       pc_plus4_i,
    input  pipe_pkg::wb_port_t                wb_i,          // writeback port
    output pipe_pkg::ex_out_t                 ex_o,
    output logic                              pc_src_o,
    output logic [rv_isa_pkg::XLEN-1:0]       pc_target_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_e_o,       // to hazard unit
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_e_o
);

    pipe_pkg::ctrl_t                   ctrl_d;
    logic [rv_isa_pkg::XLEN-1:0]       ext_imm_d;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_d;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_d;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_d;
    logic [rv_isa_pkg::XLEN-1:0]       rd1_d;
    logic [rv_isa_pkg::XLEN-1:0]       rd2_d;
    pipe_pkg::de_stage_t               stage_d;              // decode side bundle
    pipe_pkg::de_stage_t               stage_e;              // execute side bundle

    instr_decoder instr_decoder_inst (
        .instr_i   (instr_i),
        .ctrl_o    (ctrl_d),
        .ext_imm_o (ext_imm_d),
        .rs1_o     (rs1_d),
        .rs2_o     (rs2_d),
        .rd_o      (rd_d)
    );

    reg_file reg_file_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rs1_i   (rs1_d),
        .rs2_i   (rs2_d),
        .wb_i    (wb_i),
        .rd1_o   (rd1_d),
        .rd2_o   (rd2_d)
    );

    assign stage_d = '{ctrl: ctrl_d,
                       data: '{rd1: rd1_d, rd2: rd2_d, rs1: rs1_d, rs2: rs2_d, rd: rd_d,
                               pc: pc_i, ext_imm: ext_imm_d, pc_plus4: pc_plus4_i}};

    de_pipe_reg de_pipe_reg_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .stage_d_i (stage_d),
        .stage_e_o (stage_e)
    );

    exec_unit exec_unit_inst (
        .stage_e_i   (stage_e),
        .ex_o        (ex_o),
        .pc_src_o    (pc_src_o),
        .pc_target_o (pc_target_o)
    );

    assign rs1_e_o = stage_e.data.rs1;
    assign rs2_e_o = stage_e.data.rs2;

endmodule

//--- logic/de_pipe_reg.sv
// decode-to-execute pipeline register with control reset and synchronous flush
`timescale 1ns/1ns

module de_pipe_reg (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,           // insert bubble
    input  pipe_pkg::de_stage_t stage_d_i,
    output pipe_pkg::de_stage_t stage_e_o
);

    pipe_pkg::ctrl_t    ctrl_q;
    pipe_pkg::de_data_t data_q;

    // control fields cleared on reset and flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (flush_i) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= stage_d_i.ctrl;
        end
    end

    // payload registers
    always_ff @(posedge clk_i) begin
        data_q.rs1 <= stage_d_i.data.rs1;             // source numbers load even on flush
        data_q.rs2 <= stage_d_i.data.rs2;
        if (flush_i) begin
            data_q.rd1      <= '0;
            data_q.rd2      <= '0;
            data_q.rd       <= '0;
            data_q.pc       <= '0;
            data_q.ext_imm  <= '0;
            data_q.pc_plus4 <= '0;
        end else begin
            data_q.rd1      <= stage_d_i.data.rd1;
            data_q.rd2      <= stage_d_i.data.rd2;
            data_q.rd       <= stage_d_i.data.rd;
            data_q.pc       <= stage_d_i.data.pc;
            data_q.ext_imm  <= stage_d_i.data.ext_imm;
            data_q.pc_plus4 <= stage_d_i.data.pc_plus4;
        end
    end

    assign stage_e_o.ctrl = ctrl_q;
    assign stage_e_o.data = data_q;

endmodule

//--- logic/exec_unit.sv
// alu, branch decision, branch/jump target adder and execute result bundle
`timescale 1ns/1ns

module exec_unit (
    input  pipe_pkg::de_stage_t         stage_e_i,
    output pipe_pkg::ex_out_t           ex_o,
    output logic                        pc_src_o,     // redirect fetch
    output logic [rv_isa_pkg::XLEN-1:0] pc_target_o
);

    logic [rv_isa_pkg::XLEN-1:0] src_a;
    logic [rv_isa_pkg::XLEN-1:0] src_b;
    logic [rv_isa_pkg::XLEN-1:0] alu_result;
    logic [4:0]                  shamt;
    logic                        zero;                 // alu result == 0

    assign src_a = stage_e_i.data.rd1;
    assign src_b = stage_e_i.ctrl.alu_src ? stage_e_i.data.ext_imm : stage_e_i.data.rd2;
    assign shamt = src_b[4:0];

    always_comb begin
        case (stage_e_i.ctrl.alu_ctrl)
            rv_isa_pkg::ALU_ADD:    alu_result = src_a + src_b;
            rv_isa_pkg::ALU_SUB:    alu_result = src_a - src_b;
            rv_isa_pkg::ALU_AND:    alu_result = src_a & src_b;
            rv_isa_pkg::ALU_OR:     alu_result = src_a | src_b;
            rv_isa_pkg::ALU_XOR:    alu_result = src_a ^ src_b;
            rv_isa_pkg::ALU_SLT:    alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
            rv_isa_pkg::ALU_SLTU:   alu_result = {31'b0, src_a < src_b};
            rv_isa_pkg::ALU_SLL:    alu_result = src_a << shamt;
            rv_isa_pkg::ALU_SRL:    alu_result = src_a >> shamt;
            rv_isa_pkg::ALU_SRA:    alu_result = $unsigned($signed(src_a) >>> shamt);
            rv_isa_pkg::ALU_COPY_B: alu_result = src_b;    // lui
            default:                alu_result = '0;
        endcase
    end

    assign zero = (alu_result == '0);

    // pc-relative target for branches and jal
    assign pc_target_o = stage_e_i.data.pc + stage_e_i.data.ext_imm;

    // beq takes on zero and bne on non-zero
    assign pc_src_o = stage_e_i.ctrl.jump |
                      (stage_e_i.ctrl.branch & (zero ^ stage_e_i.ctrl.branch_ne));

    assign ex_o.alu_result = alu_result;
    assign ex_o.write_data = stage_e_i.data.rd2;     // store data from rs2
    assign ex_o.rd         = stage_e_i.data.rd;
    assign ex_o.pc_plus4   = stage_e_i.data.pc_plus4;
    assign ex_o.reg_w      = stage_e_i.ctrl.reg_w;
    assign ex_o.result_src = stage_e_i.ctrl.result_src;
    assign ex_o.mem_w      = stage_e_i.ctrl.mem_w;

endmodule

//--- logic/instr_decoder.sv
// main control decode, alu control decode and immediate generation for rv32i
`timescale 1ns/1ns

module instr_decoder (
    input  rv_isa_pkg::instr_u                instr_i,
    output pipe_pkg::ctrl_t                   ctrl_o,
    output logic [rv_isa_pkg::XLEN-1:0]       ext_imm_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_b5;                                   // sub / sra select bit
    rv_isa_pkg::alu_op_e alu_arith;                      // funct3-based op for alu instrs

    assign opcode = instr_i.r_fmt.opcode;
    assign funct3 = instr_i.r_fmt.funct3;
    assign f7_b5  = instr_i.r_fmt.funct7[5];
    assign rs1_o  = instr_i.r_fmt.rs1;
    assign rs2_o  = instr_i.r_fmt.rs2;
    assign rd_o   = instr_i.r_fmt.rd;

    // alu decode for OP / OP_IMM
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_ADD_SUB: alu_arith = (opcode == rv_isa_pkg::OPC_OP && f7_b5) ?
                                                rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;  // no subi
            rv_isa_pkg::F3_SLL:     alu_arith = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     alu_arith = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    alu_arith = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     alu_arith = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: alu_arith = f7_b5 ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      alu_arith = rv_isa_pkg::ALU_OR;
            default:                alu_arith = rv_isa_pkg::ALU_AND;
        endcase
    end

    // main decode where an unknown opcode leaves everything zero
    always_comb begin
        ctrl_o = '0;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                ctrl_o.reg_w    = 1'b1;
                ctrl_o.alu_ctrl = alu_arith;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                ctrl_o.reg_w    = 1'b1;
                ctrl_o.alu_src  = 1'b1;
                ctrl_o.alu_ctrl = alu_arith;
            end
            rv_isa_pkg::OPC_LOAD: begin
                ctrl_o.reg_w      = 1'b1;
                ctrl_o.result_src = rv_isa_pkg::RES_MEM;
                ctrl_o.alu_src    = 1'b1;                 // base + offset
                ctrl_o.alu_ctrl   = rv_isa_pkg::ALU_ADD;
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl_o.mem_w    = 1'b1;
                ctrl_o.alu_src  = 1'b1;
                ctrl_o.alu_ctrl = rv_isa_pkg::ALU_ADD;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                ctrl_o.branch    = 1'b1;
                ctrl_o.branch_ne = (funct3 == rv_isa_pkg::F3_BNE);
                ctrl_o.alu_ctrl  = rv_isa_pkg::ALU_SUB;   // zero flag means equal
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl_o.reg_w      = 1'b1;
                ctrl_o.jump       = 1'b1;
                ctrl_o.result_src = rv_isa_pkg::RES_PC4;  // link
                ctrl_o.alu_ctrl   = rv_isa_pkg::ALU_ADD;
            end
            rv_isa_pkg::OPC_LUI: begin
                ctrl_o.reg_w    = 1'b1;
                ctrl_o.alu_src  = 1'b1;
                ctrl_o.alu_ctrl = rv_isa_pkg::ALU_COPY_B; // imm straight through
            end
            default: ;
        endcase
    end

    // immediate assembly from the raw bit groups
    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_LOAD:  // i-type
                ext_imm_o = {{21{instr_i.imm_fmt.sign}}, instr_i.imm_fmt.hi6,
                             instr_i.imm_fmt.mid4, instr_i.imm_fmt.b20};
            rv_isa_pkg::OPC_STORE:                          // s-type
                ext_imm_o = {{21{instr_i.imm_fmt.sign}}, instr_i.imm_fmt.hi6,
                             instr_i.imm_fmt.lo4, instr_i.imm_fmt.b7};
            rv_isa_pkg::OPC_BRANCH:                         // b-type with bit 0 always 0
                ext_imm_o = {{20{instr_i.imm_fmt.sign}}, instr_i.imm_fmt.b7,
                             instr_i.imm_fmt.hi6, instr_i.imm_fmt.lo4, 1'b0};
            rv_isa_pkg::OPC_JAL:                            // j-type
                ext_imm_o = {{12{instr_i.imm_fmt.sign}}, instr_i.imm_fmt.b19_12,
                             instr_i.imm_fmt.b20, instr_i.imm_fmt.hi6,
                             instr_i.imm_fmt.mid4, 1'b0};
            rv_isa_pkg::OPC_LUI:                            // u-type with low 12 zero
                ext_imm_o = {instr_i.imm_fmt.sign, instr_i.imm_fmt.hi6, instr_i.imm_fmt.mid4,
                             instr_i.imm_fmt.b20, instr_i.imm_fmt.b19_12, 12'b0};
            default:
                ext_imm_o = '0;
        endcase
    end

endmodule

//--- logic/pipe_pkg.sv
// pipeline stage bundles: control, decode data, d-to-e stage, execute outputs, register write port
package pipe_pkg;

    typedef struct packed {
        logic                      reg_w;       // write rd at writeback
        rv_isa_pkg::result_src_e   result_src;  // alu / mem / pc+4 to rd
        logic                      mem_w;       // store
        logic                      jump;        // jal
        logic                      branch;      // conditional branch
        logic                      branch_ne;   // bne rather than beq
        rv_isa_pkg::alu_op_e       alu_ctrl;    // alu operation
        logic                      alu_src;     // operand b from immediate
    } ctrl_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]       rd1;       // rs1 value
        logic [rv_isa_pkg::XLEN-1:0]       rd2;       // rs2 value
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;       // to hazard unit
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;        // destination
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic [rv_isa_pkg::XLEN-1:0]       ext_imm;   // sign-extended immediate
        logic [rv_isa_pkg::XLEN-1:0]       pc_plus4;
    } de_data_t;

    typedef struct packed {
        ctrl_t    ctrl;
        de_data_t data;
    } de_stage_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]       alu_result;  // result or memory address
        logic [rv_isa_pkg::XLEN-1:0]       write_data;  // store data
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [rv_isa_pkg::XLEN-1:0]       pc_plus4;    // link value for jal
        logic                              reg_w;
        rv_isa_pkg::result_src_e           result_src;
        logic                              mem_w;
    } ex_out_t;

    typedef struct packed {
        logic                              we;    // write enable
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;    // target register
        logic [rv_isa_pkg::XLEN-1:0]       data;  // value to write
    } wb_port_t;

endpackage

//--- logic/reg_file.sv
// 32x32 registers with two async read ports, write-through and one sync write port
`timescale 1ns/1ns

module reg_file (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_i,
    input  pipe_pkg::wb_port_t                wb_i,
    output logic [rv_isa_pkg::XLEN-1:0]       rd1_o,
    output logic [rv_isa_pkg::XLEN-1:0]       rd2_o
);

    logic [rv_isa_pkg::XLEN-1:0] regs [rv_isa_pkg::NUM_REGS];
    logic                        wr_en;            // qualified write, never x0

    assign wr_en = wb_i.we && (wb_i.rd != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // x0 reads as zero and a same-cycle write is bypassed to the reader
    assign rd1_o = (rs1_i == '0)                 ? '0 :
                   (wr_en && wb_i.rd == rs1_i)   ? wb_i.data :
                                                   regs[rs1_i];
    assign rd2_o = (rs2_i == '0)                 ? '0 :
                   (wr_en && wb_i.rd == rs2_i)   ? wb_i.data :
                                                   regs[rs2_i];

endmodule

//--- logic/rv_isa_pkg.sv
// rv32i widths, opcode and funct3 encodings, instruction format union, alu and result-source enums
package rv_isa_pkg;

    localparam int XLEN       = 32;                  // data and address width
    localparam int REG_ADDR_W = 5;                   // register number width
    localparam int NUM_REGS   = 32;                  // x0..x31

    localparam logic [6:0] OPC_OP     = 7'b0110011;  // register alu ops
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // immediate alu ops
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;  // lw
    localparam logic [6:0] OPC_STORE  = 7'b0100011;  // sw
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // beq / bne
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;      // add, addi, sub
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;      // funct7[5] picks sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_WORD    = 3'b010;      // lw / sw width

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_COPY_B        // copy_b passes operand b (lui)
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,                             // alu result to rd
        RES_MEM = 2'b01,                             // load data to rd
        RES_PC4 = 2'b10                              // link address to rd (jal)
    } result_src_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    // raw immediate bit groups, the formats reshuffle these
    typedef struct packed {
        logic       sign;                            // instr[31]
        logic [5:0] hi6;                             // instr[30:25]
        logic [3:0] mid4;                            // instr[24:21]
        logic       b20;                             // instr[20]
        logic [7:0] b19_12;                          // instr[19:12]
        logic [3:0] lo4;                             // instr[11:8]
        logic       b7;                              // instr[7]
        logic [6:0] opcode;
    } imm_fmt_t;

    typedef union packed {
        r_fmt_t   r_fmt;                             // register fields view
        imm_fmt_t imm_fmt;                           // immediate bits view
    } instr_u;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# builds the de_ex_slice testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -f files.f \
    --top-module tb_de_ex_slice || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_de_ex_slice)"
echo "$out"
grep -qx '>>> PASS' <<< "$out" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tests/tb_ref_model.svh
// rv32i encoders, immediate sign extension, expected alu result and pc-select, xorshift
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};   // alt is funct7 bit 5
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_WORD, imm[4:0], rv_isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, rv_isa_pkg::OPC_LUI};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
endfunction

// rv32i arithmetic by funct3 where alt selects sub or sra
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic [4:0]         sh;
    sa = a;
    sh = b[4:0];                                     // only the low 5 bits shift
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << sh;
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    if (alt) return sa >>> sh; else return a >> sh;
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic taken_ref(input logic ne, input logic [31:0] a, input logic [31:0] b);
    return ne ? (a != b) : (a == b);                 // bne or beq
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

//--- tests/tb_de_ex_slice.sv
// testbench for de_ex_slice: clock, reset, directed and random stimulus, assertions, timeout, summary
`timescale 1ns/1ns

module tb_de_ex_slice;

`include "tb_ref_model.svh"

    localparam int MAX_CYCLES = 400;                 // about twice the stimulus length

    typedef struct packed {
        logic        valid;                          // slot holds an instruction to check
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        reg_w;
        logic [1:0]  rsrc;
        logic        mem_w;
        logic        pc_src;
        logic        chk_alu;                        // alu_result is defined for this op
        logic [31:0] alu;
        logic [31:0] wdata;
        logic [31:0] pc4;
        logic        chk_tgt;                        // target only matters for branch / jal
        logic [31:0] tgt;
    } exp_t;

    logic               clk_i;
    logic               rst_n_i;
    logic               flush_i;
    rv_isa_pkg::instr_u instr_i;
    logic [31:0]        pc_i;
    logic [31:0]        pc_plus4_i;
    pipe_pkg::wb_port_t wb_i;
    pipe_pkg::ex_out_t  ex_o;
    logic               pc_src_o;
    logic [31:0]        pc_target_o;
    logic [4:0]         rs1_e_o;
    logic [4:0]         rs2_e_o;

    logic [31:0]        model_regs [32];            // expected register contents
    logic [31:0]        rng;
    logic [31:0]        pc_cur;
    pipe_pkg::wb_port_t wb_cur;                     // write that goes with the next instruction
    logic               flush_cur;
    exp_t               pend;                       // instruction in decode
    exp_t               chk;                        // instruction in execute
    int                 err_cnt;
    int                 sent_cnt;
    int                 cycle_cnt = 0;

    de_ex_slice de_ex_slice_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string what);
        err_cnt++;
        $display("Mismatch at %0t ns: %s", $time, what);
    endtask

    // checked mid-cycle, when the execute outputs have settled
    a_idle: assert property (@(negedge clk_i)
        chk.valid || (!ex_o.reg_w && !ex_o.mem_w && !pc_src_o))
        else report_mismatch("control active with no instruction in execute");
    a_ctrl: assert property (@(negedge clk_i) !chk.valid || (ex_o.reg_w == chk.reg_w &&
        ex_o.mem_w == chk.mem_w && ex_o.result_src == chk.rsrc && pc_src_o == chk.pc_src))
        else report_mismatch($sformatf("reg_w/mem_w/src/pc_src %b %b %0d %b, expected %b %b %0d %b",
            ex_o.reg_w, ex_o.mem_w, ex_o.result_src, pc_src_o,
            chk.reg_w, chk.mem_w, chk.rsrc, chk.pc_src));
    a_regs: assert property (@(negedge clk_i) !chk.valid ||
        (ex_o.rd == chk.rd && rs1_e_o == chk.rs1 && rs2_e_o == chk.rs2))
        else report_mismatch($sformatf("rd/rs1/rs2 %0d %0d %0d, expected %0d %0d %0d",
            ex_o.rd, rs1_e_o, rs2_e_o, chk.rd, chk.rs1, chk.rs2));
    a_alu: assert property (@(negedge clk_i) !chk.valid || !chk.chk_alu ||
        ex_o.alu_result == chk.alu)
        else report_mismatch($sformatf("alu_result %h, expected %h", ex_o.alu_result, chk.alu));
    a_data: assert property (@(negedge clk_i) !chk.valid ||
        (ex_o.write_data == chk.wdata && ex_o.pc_plus4 == chk.pc4))
        else report_mismatch($sformatf("write_data %h pc_plus4 %h, expected %h %h",
            ex_o.write_data, ex_o.pc_plus4, chk.wdata, chk.pc4));
    a_tgt: assert property (@(negedge clk_i) !chk.valid || !chk.chk_tgt || pc_target_o == chk.tgt)
        else report_mismatch($sformatf("pc_target %h, expected %h", pc_target_o, chk.tgt));

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // x0 is zero, a write in the same cycle is seen by the read
    function automatic logic [31:0] read_model(input logic [4:0] idx);
        if (idx == 5'd0) return 32'd0;
        if (wb_cur.we && wb_cur.rd == idx) return wb_cur.data;
        return model_regs[idx];
    endfunction

    function automatic exp_t base_exp(input logic [31:0] word);
        exp_t e;
        e       = '0;
        e.valid = 1'b1;
        e.rs1   = word[19:15];
        e.rs2   = word[24:20];
        e.rd    = word[11:7];
        e.wdata = read_model(word[24:20]);          // store data is always rd2
        e.pc4   = pc_cur + 32'd4;
        return e;
    endfunction

    // drive one instruction 10 ns after the edge and advance the expected queue
    task automatic send(input logic [31:0] word, input exp_t e);
        exp_t bubble;
        @(posedge clk_i);
        #10;
        if (flush_cur) begin                         // flushed slot keeps only rs1 and rs2
            bubble         = '0;
            bubble.valid   = 1'b1;
            bubble.rs1     = e.rs1;
            bubble.rs2     = e.rs2;
            bubble.chk_tgt = 1'b1;                   // pc and immediate are zero
            e              = bubble;
        end
        instr_i    = word;
        pc_i       = pc_cur;
        pc_plus4_i = pc_cur + 32'd4;
        wb_i       = wb_cur;
        flush_i    = flush_cur;
        chk        = pend;
        pend       = e;
        if (wb_cur.we && wb_cur.rd != 5'd0) model_regs[wb_cur.rd] = wb_cur.data;
        pc_cur    = pc_cur + 32'd4;
        wb_cur    = '0;
        flush_cur = 1'b0;
        sent_cnt++;
    endtask

    task automatic issue_r(input logic alt, input logic [4:0] rs2, input logic [4:0] rs1,
                           input logic [2:0] f3, input logic [4:0] rd);
        exp_t e;
        e         = base_exp(enc_r(alt, rs2, rs1, f3, rd));
        e.reg_w   = 1'b1;
        e.chk_alu = 1'b1;
        e.alu     = alu_ref(f3, alt, read_model(rs1), read_model(rs2));
        send(enc_r(alt, rs2, rs1, f3, rd), e);
    endtask

    // kind: 0 reg alu, 1 imm alu, 2 lw, 3 sw, 4 beq/bne, 5 jal, 6 lui
    task automatic issue(input int kind);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] word;
        logic [31:0] a;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        exp_t        e;
        r   = rand32();
        s   = rand32();
        rs1 = r[4:0];
        rs2 = r[20] ? r[4:0] : r[9:5];              // equal sources now and then
        rd  = r[14:10];
        f3  = r[17:15];
        alt = r[18] && (f3 == 3'd0 || f3 == 3'd5);
        imm = s[11:0];
        a   = read_model(rs1);
        if (kind == 0) begin
            issue_r(alt, rs2, rs1, f3, rd);
        end else begin
            case (kind)
                1: begin
                    if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'b0, s[4:0]};  // shamt
                    word      = enc_i(imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM);
                    e         = base_exp(word);
                    e.reg_w   = 1'b1;
                    e.chk_alu = 1'b1;
                    e.alu     = alu_ref(f3, alt && f3 == 3'd5, a, sext12(imm));  // no subi
                end
                2: begin
                    word      = enc_i(imm, rs1, rv_isa_pkg::F3_WORD, rd, rv_isa_pkg::OPC_LOAD);
                    e         = base_exp(word);
                    e.reg_w   = 1'b1;
                    e.rsrc    = rv_isa_pkg::RES_MEM;
                    e.chk_alu = 1'b1;
                    e.alu     = a + sext12(imm);        // address
                end
                3: begin
                    word      = enc_s(imm, rs2, rs1);
                    e         = base_exp(word);
                    e.mem_w   = 1'b1;
                    e.chk_alu = 1'b1;
                    e.alu     = a + sext12(imm);
                end
                4: begin
                    word     = enc_b({s[12:1], 1'b0}, rs2, rs1,
                                     r[19] ? rv_isa_pkg::F3_BNE : rv_isa_pkg::F3_BEQ);
                    e        = base_exp(word);
                    e.pc_src = taken_ref(r[19], a, read_model(rs2));
                    e.chk_tgt = 1'b1;
                    e.tgt    = pc_cur + {{19{s[12]}}, s[12:1], 1'b0};
                end
                5: begin
                    word      = enc_j({s[20:1], 1'b0}, rd);
                    e         = base_exp(word);
                    e.reg_w   = 1'b1;
                    e.rsrc    = rv_isa_pkg::RES_PC4;    // link
                    e.pc_src  = 1'b1;
                    e.chk_tgt = 1'b1;
                    e.tgt     = pc_cur + {{11{s[20]}}, s[20:1], 1'b0};
                end
                default: begin
                    word      = enc_u(s[31:12], rd);
                    e         = base_exp(word);
                    e.reg_w   = 1'b1;
                    e.chk_alu = 1'b1;
                    e.alu     = {s[31:12], 12'b0};
                end
            endcase
            send(word, e);
        end
    endtask

    initial begin
        logic [31:0] r;
        rst_n_i    = 1'b0;
        flush_i    = 1'b0;
        instr_i    = '0;
        pc_i       = '0;
        pc_plus4_i = '0;
        wb_i       = '0;
        rng        = 32'h51549de5;
        pc_cur     = 32'h0000_1000;
        wb_cur     = '0;
        flush_cur  = 1'b0;
        pend       = '0;
        chk        = '0;
        err_cnt    = 0;
        sent_cnt   = 0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (2) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;
        repeat (3) @(posedge clk_i);                 // idle after reset
        for (int i = 1; i < 32; i++) begin           // fill, rs2 reads the register being written
            wb_cur = '{we: 1'b1, rd: 5'(i), data: rand32()};
            issue_r(1'b0, 5'(i), 5'(i - 1), 3'd0, 5'(i));
        end
        wb_cur = '{we: 1'b1, rd: 5'd0, data: rand32()};
        issue_r(1'b0, 5'd0, 5'd0, 3'd6, 5'd3);       // x0 | x0 during an x0 write
        issue_r(1'b0, 5'd0, 5'd7, 3'd0, 5'd3);
        for (int k = 0; k < 7; k++) begin
            repeat (12) issue(k);
        end
        flush_cur = 1'b1;
        issue(0);
        flush_cur = 1'b1;
        issue(5);                                    // flushed jal must not redirect
        flush_cur = 1'b1;
        issue(4);
        issue(3);
        repeat (60) begin                            // random back-to-back mix
            r = rand32();
            flush_cur = (r[3:0] == 4'd0);
            if (r[4]) wb_cur = '{we: 1'b1, rd: r[9:5], data: rand32()};
            issue(int'(r[31:28]) % 7);
        end
        send(32'd0, '0);                             // drain the queue
        send(32'd0, '0);
        @(negedge clk_i);
        #1;
        $display("summary: %0d mismatches, %0d instructions, %0d cycles",
                 err_cnt, sent_cnt, cycle_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
